/* Makefile */
# Verilator build and run of the output queue register controller testbench

VERILATOR ?= verilator
TOP       ?= oq_regs_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_TEXT := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench, fails unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/oq_regs_assertions.sv */
// Concurrent checks on the register controller FSM, attached to every controller instance by bind
module oq_regs_assertions
   import oq_types_pkg::*, oq_reg_map_pkg::*;
#(
   parameter int NUM_QUEUES = 8
) (
   input logic                  clk,
   input logic                  reset,
   input oq_state_e             state,
   input logic                  result_ready,
   input logic [NUM_QUEUES-1:0] enable,
   input oq_reg_access_t        access,
   input oq_bulk_t              bulk
);

   timeunit 1ns;
   timeprecision 1ps;

   // Failure tallies, read by the testbench for its verdict
   int ready_failures   = 0;
   int walk_failures    = 0;
   int overlap_failures = 0;
   int failure_count;

   assign failure_count = ready_failures + walk_failures + overlap_failures;

   ////////////////////////////////////////////////////////////////////////////
   // Controller properties
   ////////////////////////////////////////////////////////////////////////////

   // One result pulse per request
   result_single_pulse: assert property (
      @(posedge clk) disable iff (reset) result_ready |=> !result_ready
   ) else begin
      ready_failures++;
      $error("result_ready stayed high for two cycles");
   end

   // No queue may send before its region is loaded
   walk_enable_off: assert property (
      @(posedge clk) disable iff (reset) (state == ST_RESET_WALK) |-> (enable == '0)
   ) else begin
      walk_failures++;
      $error("enable not all zero during the reset walk");
   end

   access_bulk_exclusive: assert property (
      @(posedge clk) disable iff (reset) !(access.req && (bulk.op != BULK_NONE))
   ) else begin
      overlap_failures++;
      $error("register access and bulk operation issued together");
   end

endmodule

bind oq_regs_ctrl oq_regs_assertions #(
   .NUM_QUEUES (NUM_QUEUES)
) u_assertions (
   .clk          (clk),
   .reset        (reset),
   .state        (state),
   .result_ready (result_ready),
   .enable       (enable),
   .access       (access),
   .bulk         (bulk)
);

/* bench/oq_regs_tb.sv */
// Directed testbench for the output queue register controller, run as the simulation top
module oq_regs_tb
   import oq_types_pkg::*, oq_reg_map_pkg::*;
#(
   parameter int NUM_QUEUES      = 8,
   parameter int SRAM_ADDR_WIDTH = 19
) ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          REGION_SIZE    = (1 << SRAM_ADDR_WIDTH) / NUM_QUEUES;
   localparam int          RESET_CYCLES   = 10;
   localparam int          ACCESS_TIMEOUT = 10;
   localparam int          WALK_TIMEOUT   = 4 * NUM_QUEUES + 10;
   localparam logic [31:0] LFSR_SEED      = 32'h3479139e;
   localparam logic [31:0] LFSR_TAPS      = 32'h80200003;
   localparam oq_word_t    CTRL_ENABLE    = oq_word_t'(1 << ENABLE_SEND_BIT);
   localparam oq_word_t    CTRL_INIT      = oq_word_t'(1 << INITIALIZE_BIT);

   localparam oq_reg_addr_e WRITABLE_REGS [7] = '{REG_PKTS_STORED, REG_PKTS_DROPPED,
      REG_PKTS_REMOVED, REG_ADDR_LO, REG_ADDR_HI, REG_MAX_PKTS, REG_FULL_THRESH};
   localparam oq_reg_addr_e READ_ONLY_REGS [5] = '{REG_WR_ADDR, REG_RD_ADDR,
      REG_PKTS_IN_Q, REG_WORDS_LEFT, REG_WORDS_IN_Q};

   logic                  clk;
   logic                  reset;
   oq_host_req_t          host;
   logic                  result_ready;
   oq_word_t              reg_result;
   logic [NUM_QUEUES-1:0] enable;

   // Expected register contents and enable vector
   oq_word_t              model [NUM_QUEUES][16];
   logic [NUM_QUEUES-1:0] enable_model;
   logic [31:0]           lfsr_state;
   int                    error_count;
   int                    timeout_count;
   int                    assert_count;

   oq_regs_top #(
      .NUM_QUEUES      (NUM_QUEUES),
      .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH)
   ) UUT (
      .clk          (clk),
      .reset        (reset),
      .host         (host),
      .result_ready (result_ready),
      .reg_result   (reg_result),
      .enable       (enable)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random data and register model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic lfsr_bit();
      logic out_bit;
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
         lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      return out_bit;
   endfunction

   function automatic oq_word_t random_word();
      oq_word_t word;
      word = '0;
      for (int i = 0; i < DATA_WIDTH; i++) begin
         word = {word[DATA_WIDTH-2:0], lfsr_bit()};
      end
      return word;
   endfunction

   // Each queue owns an equal slice of the SRAM, starting at zero
   task automatic model_reset_load();
      oq_word_t lo;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         lo = oq_word_t'(q * REGION_SIZE);
         for (int a = 0; a < 16; a++) begin
            model[q][a] = '0;
         end
         model[q][REG_ADDR_LO]    = lo;
         model[q][REG_ADDR_HI]    = lo + oq_word_t'(REGION_SIZE - 1);
         model[q][REG_WR_ADDR]    = lo;
         model[q][REG_RD_ADDR]    = lo;
         model[q][REG_WORDS_LEFT] = oq_word_t'(REGION_SIZE);
         model[q][REG_MAX_PKTS]   = DEFAULT_MAX_PKTS;
      end
   endtask

   // Bounds, max pkts and threshold survive a clear
   task automatic model_clear(input int q);
      oq_word_t lo;
      oq_word_t hi;
      lo = model[q][REG_ADDR_LO];
      hi = model[q][REG_ADDR_HI];
      model[q][REG_PKTS_STORED]  = '0;
      model[q][REG_PKTS_DROPPED] = '0;
      model[q][REG_PKTS_REMOVED] = '0;
      model[q][REG_WR_ADDR]      = lo;
      model[q][REG_RD_ADDR]      = lo;
      model[q][REG_PKTS_IN_Q]    = '0;
      model[q][REG_WORDS_LEFT]   = hi - lo + 1;
      model[q][REG_WORDS_IN_Q]   = '0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Host access and checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic compare_word(input string name, input oq_word_t actual,
                               input oq_word_t expected);
      if (actual !== expected) begin
         error_count++;
         $display("ERROR %s: got %h expected %h", name, actual, expected);
      end
   endtask

   task automatic compare_enable(input logic [NUM_QUEUES-1:0] actual,
                                 input logic [NUM_QUEUES-1:0] expected);
      if (actual !== expected) begin
         error_count++;
         $display("ERROR enable: got %h expected %h", actual, expected);
      end
   endtask

   // Holds req until the result pulse, sampled on the falling edge
   task automatic host_access(input logic rd, input oq_reg_addr_e addr, input int q,
                              input oq_word_t data, output oq_word_t result);
      int cycles;
      cycles = 0;
      @(posedge clk);
      host <= '{req: 1'b1, rd_wr_l: rd, addr: addr, queue: oq_queue_t'(q), data: data};
      @(negedge clk);
      while (!result_ready && cycles < ACCESS_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      result = reg_result;
      if (!result_ready) begin
         timeout_count++;
         $display("Timeout: no result for register %0d of queue %0d", addr, q);
      end
      @(posedge clk);
      host.req <= 1'b0;
   endtask

   task automatic write_model(input oq_reg_addr_e addr, input int q, input oq_word_t data);
      oq_word_t unused;
      host_access(1'b0, addr, q, data, unused);
      model[q][addr] = data;
   endtask

   task automatic read_check(input oq_reg_addr_e addr, input int q, input oq_word_t expected);
      oq_word_t result;
      host_access(1'b1, addr, q, '0, result);
      compare_word($sformatf("reg_result q%0d reg %0d", q, addr), result, expected);
   endtask

   task automatic verify_queue(input int q);
      for (int a = REG_PKTS_STORED; a <= REG_FULL_THRESH; a++) begin
         read_check(oq_reg_addr_e'(a), q, model[q][a]);
      end
   endtask

   task automatic check_enable();
      @(negedge clk);
      compare_enable(enable, enable_model);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset_load();
      int cycles;
      cycles = 0;
      while (enable !== '1 && cycles < WALK_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (enable !== '1) begin
         timeout_count++;
         $display("Timeout: queues were not all enabled after the reset walk");
      end
      compare_enable(enable, enable_model);
      for (int q = 0; q < NUM_QUEUES; q++) begin
         verify_queue(q);
      end
   endtask

   // Second queue is verified each round to catch writes landing in the wrong queue
   task automatic test_writable_regs();
      int queues [2];
      queues = '{2, 5};
      for (int i = 0; i < 2; i++) begin
         for (int j = 0; j < 7; j++) begin
            write_model(WRITABLE_REGS[j], queues[i], random_word());
         end
         verify_queue(queues[0]);
         verify_queue(queues[1]);
      end
   endtask

   task automatic test_read_only_regs();
      oq_word_t unused;
      for (int j = 0; j < 5; j++) begin
         host_access(1'b0, READ_ONLY_REGS[j], 1, random_word(), unused);
         read_check(READ_ONLY_REGS[j], 1, model[1][READ_ONLY_REGS[j]]);
      end
      verify_queue(1);
   endtask

   task automatic test_enable_bit();
      oq_word_t unused;
      host_access(1'b0, REG_CTRL, 3, '0, unused);
      enable_model[3] = 1'b0;
      check_enable();
      read_check(REG_CTRL, 3, '0);
      host_access(1'b0, REG_CTRL, 3, CTRL_ENABLE, unused);
      enable_model[3] = 1'b1;
      check_enable();
      read_check(REG_CTRL, 3, CTRL_ENABLE);
   endtask

   // New bounds move the pointers and words left away from their reset values
   task automatic test_initialize(input logic enable_bit);
      oq_word_t unused;
      write_model(REG_PKTS_STORED, 6, random_word() | 32'h1);
      write_model(REG_PKTS_DROPPED, 6, random_word() | 32'h1);
      write_model(REG_PKTS_REMOVED, 6, random_word() | 32'h1);
      write_model(REG_MAX_PKTS, 6, random_word());
      write_model(REG_FULL_THRESH, 6, random_word());
      write_model(REG_ADDR_LO, 6, random_word());
      write_model(REG_ADDR_HI, 6, random_word());
      host_access(1'b0, REG_CTRL, 6, CTRL_INIT | (enable_bit ? CTRL_ENABLE : '0), unused);
      model_clear(6);
      enable_model[6] = enable_bit;
      check_enable();
      verify_queue(6);
      read_check(REG_CTRL, 6, enable_bit ? CTRL_ENABLE : '0);
   endtask

   task automatic test_unmapped();
      for (int code = 13; code < 16; code++) begin
         read_check(oq_reg_addr_e'(code), code - 13, BAD_ADDR_VALUE);
      end
   endtask

   initial begin
      error_count   = 0;
      timeout_count = 0;
      lfsr_state    = LFSR_SEED;
      enable_model  = '1;
      model_reset_load();
      reset <= 1'b1;
      host  <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      test_reset_load();
      test_writable_regs();
      test_read_only_regs();
      test_enable_bit();
      test_initialize(1'b1);
      test_initialize(1'b0);
      test_unmapped();

      repeat (2) @(posedge clk);
      assert_count = UUT.u_ctrl.u_assertions.failure_count;
      $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
               error_count, timeout_count, assert_count);
      if (error_count == 0 && timeout_count == 0 && assert_count == 0) begin
         $display("Simulation PASSED");
      end
      else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* compile.f */
src/oq_types_pkg.sv
src/oq_reg_map_pkg.sv
src/oq_region_walker.sv
src/oq_reg_file.sv
src/oq_regs_ctrl.sv
src/oq_regs_top.sv
bench/oq_regs_assertions.sv
bench/oq_regs_tb.sv

/* src/oq_reg_file.sv */
// Per-queue register storage with one host word access port and one whole-queue load/clear port
module oq_reg_file
   import oq_types_pkg::*, oq_reg_map_pkg::*;
#(
   parameter int NUM_QUEUES      = 8,
   parameter int SRAM_ADDR_WIDTH = 19
) (
   input  logic           clk,
   input  oq_reg_access_t access,
   input  oq_bulk_t       bulk,
   output logic           ack,
   output oq_word_t       rd_data
);

   localparam int QUEUE_BITS  = $clog2(NUM_QUEUES);
   localparam int REGION_SIZE = (1 << SRAM_ADDR_WIDTH) / NUM_QUEUES;

   // Control is handled elsewhere, so storage starts at the first counter
   localparam int FIRST_REG = int'(REG_PKTS_STORED);
   localparam int LAST_REG  = int'(REG_FULL_THRESH);

   if (!oq_params_ok(NUM_QUEUES, REGION_SIZE)) begin : g_bad_params
      $error("oq_reg_file: unsupported NUM_QUEUES or SRAM_ADDR_WIDTH");
   end

   oq_word_t              regs [NUM_QUEUES][FIRST_REG:LAST_REG];

   logic [QUEUE_BITS-1:0] acc_q;
   logic [QUEUE_BITS-1:0] blk_q;
   oq_word_t              new_lo;
   oq_word_t              new_hi;
   oq_word_t              new_words_left;

   assign acc_q = access.queue[QUEUE_BITS-1:0];
   assign blk_q = bulk.queue[QUEUE_BITS-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // Bounds used by the bulk operations
   ////////////////////////////////////////////////////////////////////////////

   // A load takes fresh bounds, a clear reuses the ones already stored
   always_comb begin
      if (bulk.op == BULK_LOAD_DEFAULTS) begin
         new_lo = bulk.addr_lo;
         new_hi = bulk.addr_hi;
      end
      else begin
         new_lo = regs[blk_q][REG_ADDR_LO];
         new_hi = regs[blk_q][REG_ADDR_HI];
      end
      new_words_left = new_hi - new_lo + 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Storage update
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // Every request is answered on the following cycle
      ack <= access.req || (bulk.op != BULK_NONE);

      if (access.req) begin
         rd_data <= regs[acc_q][access.addr];
         if (access.wr && !reg_is_read_only(access.addr)) begin
            regs[acc_q][access.addr] <= access.wr_data;
         end
      end

      if (bulk.op != BULK_NONE) begin
         // Shared by load and clear: counters, pointers and occupancy
         regs[blk_q][REG_PKTS_STORED]  <= '0;
         regs[blk_q][REG_PKTS_DROPPED] <= '0;
         regs[blk_q][REG_PKTS_REMOVED] <= '0;
         regs[blk_q][REG_WR_ADDR]      <= new_lo;
         regs[blk_q][REG_RD_ADDR]      <= new_lo;
         regs[blk_q][REG_PKTS_IN_Q]    <= '0;
         regs[blk_q][REG_WORDS_LEFT]   <= new_words_left;
         regs[blk_q][REG_WORDS_IN_Q]   <= '0;

         // Bounds and limits only change on the reset load
         if (bulk.op == BULK_LOAD_DEFAULTS) begin
            regs[blk_q][REG_ADDR_LO]     <= new_lo;
            regs[blk_q][REG_ADDR_HI]     <= new_hi;
            regs[blk_q][REG_MAX_PKTS]    <= DEFAULT_MAX_PKTS;
            regs[blk_q][REG_FULL_THRESH] <= '0;
         end
      end
   end

endmodule

/* src/oq_reg_map_pkg.sv */
// Host-visible register map of the output queues: addresses, control bits, defaults and request
package oq_reg_map_pkg;

   import oq_types_pkg::*;

   // Per-queue register codes as seen by the host, 13 to 15 are unmapped
   typedef enum logic [3:0] {
      REG_CTRL         = 4'd0,
      REG_PKTS_STORED  = 4'd1,
      REG_PKTS_DROPPED = 4'd2,
      REG_PKTS_REMOVED = 4'd3,
      REG_ADDR_LO      = 4'd4,
      REG_ADDR_HI      = 4'd5,
      REG_WR_ADDR      = 4'd6,
      REG_RD_ADDR      = 4'd7,
      REG_MAX_PKTS     = 4'd8,
      REG_PKTS_IN_Q    = 4'd9,
      REG_WORDS_LEFT   = 4'd10,
      REG_WORDS_IN_Q   = 4'd11,
      REG_FULL_THRESH  = 4'd12
   } oq_reg_addr_e;

   // Control word bits
   localparam int ENABLE_SEND_BIT = 0;
   localparam int INITIALIZE_BIT  = 1;

   localparam oq_word_t DEFAULT_MAX_PKTS = 32'd1024;
   localparam oq_word_t BAD_ADDR_VALUE   = 32'hdeadbeef;

   // Host request, held stable while req is high
   typedef struct packed {
      logic         req;
      logic         rd_wr_l;
      oq_reg_addr_e addr;
      oq_queue_t    queue;
      oq_word_t     data;
   } oq_host_req_t;

   // Single-word access into the register file
   typedef struct packed {
      logic         req;
      logic         wr;
      oq_reg_addr_e addr;
      oq_queue_t    queue;
      oq_word_t     wr_data;
   } oq_reg_access_t;

   // Pointers and occupancy are owned by the queue logic, host writes are dropped
   function automatic logic reg_is_read_only(oq_reg_addr_e addr);
      return addr == REG_WR_ADDR || addr == REG_RD_ADDR || addr == REG_PKTS_IN_Q ||
             addr == REG_WORDS_LEFT || addr == REG_WORDS_IN_Q;
   endfunction

endpackage

/* src/oq_region_walker.sv */
// Steps through the queues after reset, producing each queue's SRAM region bounds in turn
module oq_region_walker
   import oq_types_pkg::*;
#(
   parameter int NUM_QUEUES      = 8,
   parameter int SRAM_ADDR_WIDTH = 19
) (
   input  logic     clk,
   input  logic     reset,
   output oq_walk_t walk
);

   // Each queue owns an equal slice of the SRAM
   localparam int REGION_SIZE = (1 << SRAM_ADDR_WIDTH) / NUM_QUEUES;

   if (!oq_params_ok(NUM_QUEUES, REGION_SIZE)) begin : g_bad_params
      $error("oq_region_walker: unsupported NUM_QUEUES or SRAM_ADDR_WIDTH");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Queue counter and running bounds
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         walk.queue   <= '0;
         walk.addr_lo <= '0;
         walk.addr_hi <= oq_word_t'(REGION_SIZE - 1);
         walk.last    <= 1'b0;
      end
      else if (!walk.last) begin
         // Advance one region per cycle until the final queue, then hold
         walk.queue   <= walk.queue + 1'b1;
         walk.addr_lo <= walk.addr_lo + oq_word_t'(REGION_SIZE);
         walk.addr_hi <= walk.addr_hi + oq_word_t'(REGION_SIZE);
         walk.last    <= (walk.queue == oq_queue_t'(NUM_QUEUES - 2));
      end
   end

endmodule

/* src/oq_regs_ctrl.sv */
// Main FSM for output queue registers: decodes host requests, runs reset load and queue init
module oq_regs_ctrl
   import oq_types_pkg::*, oq_reg_map_pkg::*;
#(
   parameter int NUM_QUEUES      = 8,
   parameter int SRAM_ADDR_WIDTH = 19
) (
   input  logic                  clk,
   input  logic                  reset,
   input  oq_host_req_t          host,
   input  oq_walk_t              walk,
   input  logic                  ack,
   input  oq_word_t              rd_data,
   output oq_reg_access_t        access,
   output oq_bulk_t              bulk,
   output logic                  result_ready,
   output oq_word_t              reg_result,
   output logic [NUM_QUEUES-1:0] enable
);

   localparam int QUEUE_BITS  = $clog2(NUM_QUEUES);
   localparam int REGION_SIZE = (1 << SRAM_ADDR_WIDTH) / NUM_QUEUES;

   if (!oq_params_ok(NUM_QUEUES, REGION_SIZE)) begin : g_bad_params
      $error("oq_regs_ctrl: unsupported NUM_QUEUES or SRAM_ADDR_WIDTH");
   end

   oq_state_e             state;

   // Request tracking
   logic                  in_progress;
   logic                  req_taken;

   // Queue being initialized and the enable value it gets afterwards
   logic [QUEUE_BITS-1:0] init_queue;
   logic                  enable_held;

   // Register file request, control and payload parts
   logic                  access_req;
   logic                  access_wr;
   oq_reg_addr_e          access_addr;
   oq_queue_t             access_queue;
   oq_word_t              access_data;
   oq_bulk_op_e           bulk_op;
   oq_queue_t             bulk_queue;
   oq_word_t              bulk_lo;
   oq_word_t              bulk_hi;

   // Host request decode
   logic [QUEUE_BITS-1:0] host_q;
   logic                  is_mapped;
   logic                  is_ctrl;
   logic                  want_init;
   oq_word_t              ctrl_result;

   assign host_q    = host.queue[QUEUE_BITS-1:0];
   assign is_mapped = (host.addr <= REG_FULL_THRESH);
   assign is_ctrl   = (host.addr == REG_CTRL);
   assign want_init = !host.rd_wr_l && host.data[INITIALIZE_BIT];

   // A read returns the current bit, a write echoes the bit just written
   always_comb begin
      ctrl_result = '0;
      ctrl_result[ENABLE_SEND_BIT] = host.rd_wr_l ? enable[host_q] : host.data[ENABLE_SEND_BIT];
   end

   assign access = '{req: access_req, wr: access_wr, addr: access_addr,
                     queue: access_queue, wr_data: access_data};
   assign bulk   = '{op: bulk_op, queue: bulk_queue, addr_lo: bulk_lo, addr_hi: bulk_hi};

   ////////////////////////////////////////////////////////////////////////////
   // Main state machine
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= ST_RESET_WALK;
         enable       <= '0;
         result_ready <= 1'b0;
         access_req   <= 1'b0;
         bulk_op      <= BULK_NONE;
         in_progress  <= 1'b0;
         req_taken    <= 1'b0;
      end
      else begin
         // Single-cycle pulses by default
         result_ready <= 1'b0;
         access_req   <= 1'b0;
         bulk_op      <= BULK_NONE;

         // A request level is served once, until the host lets go of it
         if (!host.req) begin
            req_taken <= 1'b0;
         end

         case (state)
            ST_RESET_WALK: begin
               bulk_op <= BULK_LOAD_DEFAULTS;
               if (walk.last) begin
                  // Wait out the ack of the final load before serving the host
                  state  <= ST_INIT_PAUSE;
                  enable <= '1;
               end
            end

            ST_NORMAL: begin
               if (in_progress) begin
                  if (!host.req) begin
                     // Host gave up, so the ack is dropped
                     in_progress <= 1'b0;
                  end
                  else if (ack) begin
                     in_progress  <= 1'b0;
                     result_ready <= 1'b1;
                  end
               end
               else if (host.req && !req_taken) begin
                  req_taken <= 1'b1;
                  if (!is_mapped || (is_ctrl && !want_init)) begin
                     // Answered here without the register file
                     result_ready <= 1'b1;
                     if (is_ctrl && !host.rd_wr_l) begin
                        enable[host_q] <= host.data[ENABLE_SEND_BIT];
                     end
                  end
                  else if (is_ctrl) begin
                     // Queue stays off until its clear has gone through
                     state          <= ST_INIT_CLEAR;
                     enable[host_q] <= 1'b0;
                     enable_held    <= host.data[ENABLE_SEND_BIT];
                     init_queue     <= host_q;
                     bulk_op        <= BULK_CLEAR_QUEUE;
                  end
                  else begin
                     access_req  <= 1'b1;
                     in_progress <= 1'b1;
                  end
               end
            end

            ST_INIT_CLEAR: begin
               enable[init_queue] <= enable_held;
               result_ready       <= host.req;
               state              <= ST_INIT_PAUSE;
            end

            ST_INIT_PAUSE: begin
               if (ack) begin
                  state <= ST_NORMAL;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Payload registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      access_wr    <= !host.rd_wr_l;
      access_addr  <= host.addr;
      access_queue <= host.queue;
      access_data  <= host.data;

      // Walk bounds feed the reset load, the clear only needs the queue
      bulk_queue <= (state == ST_RESET_WALK) ? walk.queue : host.queue;
      bulk_lo    <= walk.addr_lo;
      bulk_hi    <= walk.addr_hi;

      if (in_progress) begin
         reg_result <= rd_data;
      end
      else if (!is_mapped) begin
         reg_result <= BAD_ADDR_VALUE;
      end
      else begin
         reg_result <= ctrl_result;
      end
   end

endmodule

/* src/oq_regs_top.sv */
// Top level of the output queue register controller, sets sizing and connects walker, FSM, storage
module oq_regs_top
   import oq_types_pkg::*, oq_reg_map_pkg::*;
#(
   parameter int NUM_QUEUES      = 8,
   parameter int SRAM_ADDR_WIDTH = 19
) (
   input  logic                  clk,
   input  logic                  reset,
   input  oq_host_req_t          host,
   output logic                  result_ready,
   output oq_word_t              reg_result,
   output logic [NUM_QUEUES-1:0] enable
);

   oq_walk_t       walk;
   oq_reg_access_t access;
   oq_bulk_t       bulk;
   logic           ack;
   oq_word_t       rd_data;

   ////////////////////////////////////////////////////////////////////////////
   // Region walker, controller and register file
   ////////////////////////////////////////////////////////////////////////////

   oq_region_walker #(
      .NUM_QUEUES      (NUM_QUEUES),
      .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH)
   ) u_walker (
      .clk   (clk),
      .reset (reset),
      .walk  (walk)
   );

   oq_regs_ctrl #(
      .NUM_QUEUES      (NUM_QUEUES),
      .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH)
   ) u_ctrl (
      .clk          (clk),
      .reset        (reset),
      .host         (host),
      .walk         (walk),
      .ack          (ack),
      .rd_data      (rd_data),
      .access       (access),
      .bulk         (bulk),
      .result_ready (result_ready),
      .reg_result   (reg_result),
      .enable       (enable)
   );

   oq_reg_file #(
      .NUM_QUEUES      (NUM_QUEUES),
      .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH)
   ) u_reg_file (
      .clk     (clk),
      .access  (access),
      .bulk    (bulk),
      .ack     (ack),
      .rd_data (rd_data)
   );

endmodule

/* src/oq_types_pkg.sv */
// Word, queue index, bulk operation and FSM state types shared by the output queue register RTL
package oq_types_pkg;

   localparam int DATA_WIDTH     = 32;
   localparam int MAX_QUEUE_BITS = 4;

   typedef logic [DATA_WIDTH-1:0]     oq_word_t;
   typedef logic [MAX_QUEUE_BITS-1:0] oq_queue_t;

   // Whole-queue operations carried out by the register file in one cycle
   typedef enum logic [1:0] {
      BULK_NONE          = 2'd0,
      BULK_LOAD_DEFAULTS = 2'd1,
      BULK_CLEAR_QUEUE   = 2'd2
   } oq_bulk_op_e;

   // Bounds are only consumed by BULK_LOAD_DEFAULTS
   typedef struct packed {
      oq_bulk_op_e op;
      oq_queue_t   queue;
      oq_word_t    addr_lo;
      oq_word_t    addr_hi;
   } oq_bulk_t;

   typedef struct packed {
      oq_queue_t queue;
      oq_word_t  addr_lo;
      oq_word_t  addr_hi;
      logic      last;
   } oq_walk_t;

   typedef enum logic [1:0] {
      ST_RESET_WALK = 2'd0,
      ST_NORMAL     = 2'd1,
      ST_INIT_CLEAR = 2'd2,
      ST_INIT_PAUSE = 2'd3
   } oq_state_e;

   // Power-of-two queue count that fits the index fields, and nonempty SRAM regions
   function automatic bit oq_params_ok(int num_queues, int region_size);
      return num_queues >= 2 && num_queues <= (1 << MAX_QUEUE_BITS) &&
             (num_queues & (num_queues - 1)) == 0 && region_size >= 1;
   endfunction

endpackage
